// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module dispatch_tb -f ooo_dispatch.f
	out=$$(./obj_dir/Vdispatch_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qF "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== dv/dispatch_checker.sv ====
`timescale 1ns/100ps

module dispatch_checker (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic                                 exp_valid,
	input  logic [ooo_dispatch_pkg::INSTR_W-1:0] exp_word,
	input  logic [ooo_dispatch_pkg::CLS_W-1:0]   exp_cls,
	input  logic [ooo_dispatch_pkg::TAG_W-1:0]   exp_rd_tag,
	input  logic [ooo_dispatch_pkg::TAG_W-1:0]   exp_rs1_tag,
	input  logic [ooo_dispatch_pkg::TAG_W-1:0]   exp_rs2_tag,
	input  logic                                 alu_pop,
	input  logic                                 alu_empty,
	input  logic [ooo_dispatch_pkg::ISSUE_W-1:0] alu_data,
	input  logic                                 bru_pop,
	input  logic                                 bru_empty,
	input  logic [ooo_dispatch_pkg::ISSUE_W-1:0] bru_data,
	input  logic                                 lu_pop,
	input  logic                                 lu_empty,
	input  logic [ooo_dispatch_pkg::ISSUE_W-1:0] lu_data,
	input  logic                                 su_pop,
	input  logic                                 su_empty,
	input  logic [ooo_dispatch_pkg::ISSUE_W-1:0] su_data,
	input  logic                                 csr_pop,
	input  logic                                 csr_empty,
	input  logic [ooo_dispatch_pkg::ISSUE_W-1:0] csr_data,
	input  logic                                 rob_pop,
	input  logic                                 rob_empty,
	input  logic [ooo_dispatch_pkg::ROB_W-1:0]   rob_head,
	output int                                   errors,
	output int                                   outstanding,
	output int                                   retired
);

	localparam int INSTR_W = ooo_dispatch_pkg::INSTR_W;
	localparam int ISSUE_W = ooo_dispatch_pkg::ISSUE_W;
	localparam int ROB_W = ooo_dispatch_pkg::ROB_W;
	localparam int IMM_LSB = 3 * ooo_dispatch_pkg::REG_W + 1;

	logic [ooo_dispatch_pkg::OP_W-1:0] e_op;
	logic [ooo_dispatch_pkg::PC_W-1:0] e_pc;
	ooo_dispatch_pkg::imm_u            e_imm;
	logic                              e_has_rd;
	logic                              e_fence_i;
	logic                              guard_su;
	logic                              guard_lu;

	// expected entries carry the store and load counts that must leave first
	// issue lists are indexed by class
	logic [31+ISSUE_W:0] issue_exp [5][$];
	logic [31+ROB_W:0]   rob_exp [$];

	logic [4:0]         q_pop;
	logic [4:0]         q_empty;
	logic [ISSUE_W-1:0] q_data [5];
	string              q_name [5] = '{"alu", "bru", "lu", "su", "csr"};

	int err_cnt = 0;
	int pend_cnt = 0;
	int ret_cnt = 0;
	int su_queued = 0;
	int lu_queued = 0;
	int su_left = 0;
	int lu_left = 0;
	int su_need = 0;
	int lu_need = 0;

	assign errors = err_cnt;
	assign outstanding = pend_cnt;
	assign retired = ret_cnt;

	assign {e_op, e_pc, e_imm} = exp_word[INSTR_W-ooo_dispatch_pkg::CLS_W-1:IMM_LSB];
	assign e_has_rd = exp_word[0];

	// fence.i or a matching set in pred and succ guards a queue
	assign e_fence_i = (e_op == ooo_dispatch_pkg::OP_FENCE_I);
	assign guard_su = (exp_cls == ooo_dispatch_pkg::CLS_FENCE) & (e_fence_i |
		((|(e_imm.fence.pred & 4'b0101)) & (|(e_imm.fence.succ & 4'b0101))));
	assign guard_lu = (exp_cls == ooo_dispatch_pkg::CLS_FENCE) & (e_fence_i |
		((|(e_imm.fence.pred & 4'b1010)) & (|(e_imm.fence.succ & 4'b1010))));

	assign q_pop = {csr_pop, su_pop, lu_pop, bru_pop, alu_pop};
	assign q_empty = {csr_empty, su_empty, lu_empty, bru_empty, alu_empty};
	assign q_data[0] = alu_data;
	assign q_data[1] = bru_data;
	assign q_data[2] = lu_data;
	assign q_data[3] = su_data;
	assign q_data[4] = csr_data;

	function automatic logic order_ok(input logic [31:0] need);
		return (su_left >= int'(need[31:16])) && (lu_left >= int'(need[15:0]));
	endfunction

	always @(posedge clk) begin : compare
		logic [31+ISSUE_W:0] want;
		logic [31+ROB_W:0]   want_rob;
		int                  pending;
		if (arst_n) begin
			if (exp_valid) begin
				if (guard_su) begin
					su_need = su_queued;
				end
				if (guard_lu) begin
					lu_need = lu_queued;
				end
				rob_exp.push_back({su_need[15:0], lu_need[15:0],
					e_pc, exp_rd_tag, e_has_rd,
					exp_cls == ooo_dispatch_pkg::CLS_BRU,
					exp_cls == ooo_dispatch_pkg::CLS_SU,
					exp_cls == ooo_dispatch_pkg::CLS_CSR,
					exp_cls == ooo_dispatch_pkg::CLS_FENCE});
				// a fence has no issue entry
				if (exp_cls < ooo_dispatch_pkg::CLS_FENCE) begin
					issue_exp[exp_cls].push_back({su_need[15:0], lu_need[15:0],
						e_op, e_pc, e_imm, exp_rd_tag, exp_rs1_tag, exp_rs2_tag});
				end
				if (exp_cls == ooo_dispatch_pkg::CLS_SU) begin
					su_queued++;
				end
				if (exp_cls == ooo_dispatch_pkg::CLS_LU) begin
					lu_queued++;
				end
			end
			for (int i = 0; i < 5; i++) begin
				if (q_pop[i] && !q_empty[i]) begin
					if (issue_exp[i].size() == 0) begin
						err_cnt++;
						$display("ERROR: %0t an unexpected entry left the %s queue",
							$time, q_name[i]);
					end else begin
						want = issue_exp[i].pop_front();
						if (q_data[i] !== want[ISSUE_W-1:0]) begin
							err_cnt++;
							$display("FAIL %0t: %s queue entry %h, expected %h",
								$time, q_name[i], q_data[i], want[ISSUE_W-1:0]);
						end
						if (!order_ok(want[ISSUE_W +: 32])) begin
							err_cnt++;
							$display("ERROR: %0t the %s queue released an entry %s",
								$time, q_name[i], "that a fence should still hold back");
						end
					end
					if (i == 2) begin
						lu_left++;
					end
					if (i == 3) begin
						su_left++;
					end
				end
			end
			if (rob_pop && !rob_empty) begin
				ret_cnt++;
				if (rob_exp.size() == 0) begin
					err_cnt++;
					$display("ERROR: %0t an unexpected entry retired from the reorder buffer",
						$time);
				end else begin
					want_rob = rob_exp.pop_front();
					if (rob_head !== want_rob[ROB_W-1:0]) begin
						err_cnt++;
						$display("FAIL %0t: reorder entry %h, expected %h",
							$time, rob_head, want_rob[ROB_W-1:0]);
					end
					if (!order_ok(want_rob[ROB_W +: 32])) begin
						err_cnt++;
						$display("ERROR: %0t the reorder buffer retired an entry %s",
							$time, "that a fence should still hold back");
					end
				end
			end
			pending = rob_exp.size();
			for (int i = 0; i < 5; i++) begin
				pending += issue_exp[i].size();
			end
			pend_cnt = pending;
		end
	end

endmodule

// ==== dv/dispatch_properties.sv ====
`timescale 1ns/100ps

module dispatch_properties (
	input logic clk,
	input logic arst_n,
	input logic iq_pop,
	input logic rob_push,
	input logic rob_full,
	input logic alu_push,
	input logic bru_push,
	input logic lu_push,
	input logic su_push,
	input logic csr_push,
	input logic alu_full,
	input logic bru_full,
	input logic lu_full,
	input logic su_full,
	input logic csr_full
);

	logic [4:0] issue_push;
	logic [4:0] issue_full;

	int fail_cnt = 0;

	assign issue_push = {csr_push, su_push, lu_push, bru_push, alu_push};
	assign issue_full = {csr_full, su_full, lu_full, bru_full, alu_full};

	a_issue_not_full: assert property (@(posedge clk) disable iff (!arst_n)
		(issue_push & issue_full) == '0)
		else begin
			$error("issue queue pushed while full");
			fail_cnt++;
		end

	a_rob_not_full: assert property (@(posedge clk) disable iff (!arst_n)
		rob_push |-> !rob_full)
		else begin
			$error("reorder buffer pushed while full");
			fail_cnt++;
		end

	a_one_issue: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(issue_push))
		else begin
			$error("more than one issue queue pushed in a cycle");
			fail_cnt++;
		end

	a_pop_is_rob_push: assert property (@(posedge clk) disable iff (!arst_n)
		iq_pop == rob_push)
		else begin
			$error("instruction queue pop and reorder push differ");
			fail_cnt++;
		end

	// the instruction queue is still empty right after reset
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> (issue_push == '0) && !rob_push)
		else begin
			$error("push in the first cycle after reset");
			fail_cnt++;
		end

endmodule

bind dispatch_top dispatch_properties u_props (
	.clk      (clk),
	.arst_n   (arst_n),
	.iq_pop   (iq_pop),
	.rob_push (rob_push),
	.rob_full (rob_full),
	.alu_push (alu_push),
	.bru_push (bru_push),
	.lu_push  (lu_push),
	.su_push  (su_push),
	.csr_push (csr_push),
	.alu_full (alu_full),
	.bru_full (bru_full),
	.lu_full  (lu_full),
	.su_full  (su_full),
	.csr_full (csr_full)
);

// ==== dv/dispatch_tb.sv ====
`timescale 1ns/100ps

module dispatch_tb;

	localparam int INSTR_W = ooo_dispatch_pkg::INSTR_W;
	localparam int ISSUE_W = ooo_dispatch_pkg::ISSUE_W;
	localparam int ROB_W = ooo_dispatch_pkg::ROB_W;
	localparam int TAG_W = ooo_dispatch_pkg::TAG_W;
	localparam int CLS_W = ooo_dispatch_pkg::CLS_W;

	logic               clk;
	logic               arst_n;
	logic               instr_push;
	logic               instr_full;
	logic [INSTR_W-1:0] instr_word;
	logic               alu_pop;
	logic               alu_empty;
	logic [ISSUE_W-1:0] alu_data;
	logic               bru_pop;
	logic               bru_empty;
	logic [ISSUE_W-1:0] bru_data;
	logic               lu_pop;
	logic               lu_empty;
	logic [ISSUE_W-1:0] lu_data;
	logic               su_pop;
	logic               su_empty;
	logic [ISSUE_W-1:0] su_data;
	logic               csr_pop;
	logic               csr_empty;
	logic [ISSUE_W-1:0] csr_data;
	logic               rob_pop;
	logic               rob_empty;
	logic [ROB_W-1:0]   rob_head;

	logic               exp_valid;
	logic [INSTR_W-1:0] exp_word;
	logic [CLS_W-1:0]   exp_cls;
	logic [TAG_W-1:0]   exp_rd_tag;
	logic [TAG_W-1:0]   exp_rs1_tag;
	logic [TAG_W-1:0]   exp_rs2_tag;

	int chk_errors;
	int chk_outstanding;
	int chk_retired;

	// test records from the data file
	logic [INSTR_W-1:0] t_word [$];
	logic [CLS_W-1:0]   t_cls [$];
	logic [TAG_W-1:0]   t_rd [$];
	logic [TAG_W-1:0]   t_rs1 [$];
	logic [TAG_W-1:0]   t_rs2 [$];

	int n_lines = 0;
	int load_errors = 0;

	dispatch_top dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.instr_push (instr_push),
		.instr_full (instr_full),
		.instr_word (instr_word),
		.alu_pop    (alu_pop),
		.alu_empty  (alu_empty),
		.alu_data   (alu_data),
		.bru_pop    (bru_pop),
		.bru_empty  (bru_empty),
		.bru_data   (bru_data),
		.lu_pop     (lu_pop),
		.lu_empty   (lu_empty),
		.lu_data    (lu_data),
		.su_pop     (su_pop),
		.su_empty   (su_empty),
		.su_data    (su_data),
		.csr_pop    (csr_pop),
		.csr_empty  (csr_empty),
		.csr_data   (csr_data),
		.rob_pop    (rob_pop),
		.rob_empty  (rob_empty),
		.rob_head   (rob_head)
	);

	dispatch_checker u_checker (
		.clk         (clk),
		.arst_n      (arst_n),
		.exp_valid   (exp_valid),
		.exp_word    (exp_word),
		.exp_cls     (exp_cls),
		.exp_rd_tag  (exp_rd_tag),
		.exp_rs1_tag (exp_rs1_tag),
		.exp_rs2_tag (exp_rs2_tag),
		.alu_pop     (alu_pop),
		.alu_empty   (alu_empty),
		.alu_data    (alu_data),
		.bru_pop     (bru_pop),
		.bru_empty   (bru_empty),
		.bru_data    (bru_data),
		.lu_pop      (lu_pop),
		.lu_empty    (lu_empty),
		.lu_data     (lu_data),
		.su_pop      (su_pop),
		.su_empty    (su_empty),
		.su_data     (su_data),
		.csr_pop     (csr_pop),
		.csr_empty   (csr_empty),
		.csr_data    (csr_data),
		.rob_pop     (rob_pop),
		.rob_empty   (rob_empty),
		.rob_head    (rob_head),
		.errors      (chk_errors),
		.outstanding (chk_outstanding),
		.retired     (chk_retired)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic read_tests();
		int                 fd;
		string              line;
		logic [INSTR_W-1:0] w;
		logic [CLS_W-1:0]   c;
		logic [TAG_W-1:0]   rt;
		logic [TAG_W-1:0]   r1;
		logic [TAG_W-1:0]   r2;
		fd = $fopen("dv/dispatch_tests.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open dv/dispatch_tests.txt");
			load_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					if ($sscanf(line, "%h %h %h %h %h", w, c, rt, r1, r2) == 5) begin
						t_word.push_back(w);
						t_cls.push_back(c);
						t_rd.push_back(rt);
						t_rs1.push_back(r1);
						t_rs2.push_back(r2);
					end
				end
			end
			$fclose(fd);
			if (t_word.size() == 0) begin
				$display("ERROR: the test file holds no instructions");
				load_errors++;
			end
		end
	endtask

	// one instruction per cycle while the instruction queue has room
	task automatic send_tests();
		int idx;
		idx = 0;
		while (idx < n_lines) begin
			@(negedge clk);
			if (!instr_full) begin
				instr_push = 1'b1;
				instr_word = t_word[idx];
				exp_valid = 1'b1;
				exp_word = t_word[idx];
				exp_cls = t_cls[idx];
				exp_rd_tag = t_rd[idx];
				exp_rs1_tag = t_rs1[idx];
				exp_rs2_tag = t_rs2[idx];
				idx++;
			end else begin
				instr_push = 1'b0;
				exp_valid = 1'b0;
			end
		end
		@(negedge clk);
		instr_push = 1'b0;
		exp_valid = 1'b0;
	endtask

	initial begin : pop_driver
		logic [31:0] lfsr;
		logic [5:0]  pick;
		lfsr = 32'hc2105ddc;
		{alu_pop, bru_pop, lu_pop, su_pop, csr_pop, rob_pop} = '0;
		wait (arst_n === 1'b1);
		// nothing drains at first, so back-pressure, rename stalls and fence holds occur
		repeat (24) @(negedge clk);
		forever begin
			@(negedge clk);
			for (int i = 0; i < 6; i++) begin
				lfsr = lfsr_step(lfsr);
				pick[i] = lfsr[0];
			end
			{alu_pop, bru_pop, lu_pop, su_pop, csr_pop, rob_pop} = pick;
		end
	end

	initial begin : watchdog
		wait (n_lines > 0);
		repeat (n_lines * 200) @(posedge clk);
		$display("ERROR: timed out, the queues did not drain within %0d cycles",
			n_lines * 200);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main
		int end_errors;
		int prop_errors;
		end_errors = 0;
		prop_errors = 0;
		arst_n = 1'b0;
		instr_push = 1'b0;
		instr_word = '0;
		exp_valid = 1'b0;
		exp_word = '0;
		exp_cls = '0;
		exp_rd_tag = '0;
		exp_rs1_tag = '0;
		exp_rs2_tag = '0;
		read_tests();
		if (load_errors == 0) begin
			n_lines = t_word.size();
			repeat (5) @(posedge clk);
			@(negedge clk);
			arst_n = 1'b1;
			send_tests();
			while (chk_outstanding != 0) begin
				@(negedge clk);
			end
			// extra cycles catch duplicated entries
			repeat (8) @(negedge clk);
			if (chk_retired != n_lines) begin
				$display("ERROR: %0d entries retired for %0d instructions",
					chk_retired, n_lines);
				end_errors++;
			end
			if (!(alu_empty && bru_empty && lu_empty && su_empty && csr_empty && rob_empty)) begin
				$display("ERROR: a queue still holds entries at the end of the run");
				end_errors++;
			end
		end
		prop_errors = dut.u_props.fail_cnt;
		$display("errors: %0d compare, %0d assertion, %0d load, %0d end of run",
			chk_errors, prop_errors, load_errors, end_errors);
		if (chk_errors == 0 && prop_errors == 0 && load_errors == 0 &&
			end_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== dv/dispatch_tests.txt ====
# instruction word {cls, op, pc, imm, rd, rs1, rs2, has_rd}, expected class,
# expected rd tag, rs1 tag and rs2 tag, tags are {register, copy}, all hex
00000010000002845 0 15 04 08
01000010040002947 0 16 15 0c
0200001008000294b 0 17 16 16
000000100c0002941 0 14 17 00
1300001010000014c 1 01 14 18
3200001014000008a 3 01 08 14
23000010180003081 2 19 08 00
500000101c0330000 5 01 00 00
0000001020000398b 0 1d 19 14
410000102430041c1 4 21 1d 00
3300001028000020e 3 01 21 1d
510000102c0000000 5 01 00 00
00000010300002943 0 15 14 04
20000010340004941 2 25 15 00
50000010380120000 5 01 00 00
100000103c0000801 1 05 00 00
01000010400000853 0 06 05 25
4200001044c005041 4 29 06 00
31000010480000282 3 01 29 06
020000104c000294b 0 16 15 15

// ==== hdl/dispatch.sv ====
`timescale 1ns/100ps

module dispatch (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic                                 iq_empty,
	input  logic [ooo_dispatch_pkg::INSTR_W-1:0] iq_head,
	output logic                                 iq_pop,
	input  logic                                 rob_full,
	output logic                                 rob_push,
	output logic [ooo_dispatch_pkg::ROB_W-1:0]   rob_info,
	input  logic                                 alu_full,
	input  logic                                 bru_full,
	input  logic                                 lu_full,
	input  logic                                 su_full,
	input  logic                                 csr_full,
	output logic                                 alu_push,
	output logic                                 bru_push,
	output logic                                 lu_push,
	output logic                                 su_push,
	output logic                                 csr_push,
	output logic [ooo_dispatch_pkg::ISSUE_W-1:0] issue_info,
	input  logic                                 su_empty,
	input  logic                                 lu_empty,
	input  logic                                 rel_valid,
	input  logic [ooo_dispatch_pkg::TAG_W-1:0]   rel_tag
);

	logic [ooo_dispatch_pkg::CLS_W-1:0] cls;
	logic [ooo_dispatch_pkg::OP_W-1:0]  op;
	logic [ooo_dispatch_pkg::PC_W-1:0]  pc;
	ooo_dispatch_pkg::imm_u             imm;
	logic [ooo_dispatch_pkg::REG_W-1:0] rd;
	logic [ooo_dispatch_pkg::REG_W-1:0] rs1;
	logic [ooo_dispatch_pkg::REG_W-1:0] rs2;
	logic                               has_rd;

	logic [ooo_dispatch_pkg::TAG_W-1:0] rd_tag;
	logic [ooo_dispatch_pkg::TAG_W-1:0] rs1_tag;
	logic [ooo_dispatch_pkg::TAG_W-1:0] rs2_tag;
	logic                               run_out;

	logic disp_ok;
	logic is_fence;
	logic is_fence_i;
	logic pred_s;
	logic pred_l;
	logic succ_s;
	logic succ_l;
	logic fence_hold;
	logic fence_go;

	assign {cls, op, pc, imm, rd, rs1, rs2, has_rd} = iq_head;

	assign disp_ok = ~iq_empty & ~rob_full & ~run_out;

	assign alu_push = disp_ok & (cls == ooo_dispatch_pkg::CLS_ALU) & ~alu_full;
	assign bru_push = disp_ok & (cls == ooo_dispatch_pkg::CLS_BRU) & ~bru_full;
	assign lu_push = disp_ok & (cls == ooo_dispatch_pkg::CLS_LU) & ~lu_full;
	assign su_push = disp_ok & (cls == ooo_dispatch_pkg::CLS_SU) & ~su_full;
	assign csr_push = disp_ok & (cls == ooo_dispatch_pkg::CLS_CSR) & ~csr_full;

	assign is_fence = (cls == ooo_dispatch_pkg::CLS_FENCE);
	assign is_fence_i = is_fence & (op == ooo_dispatch_pkg::OP_FENCE_I);

	// store side is o or w, read side is i or r
	assign pred_s = imm.fence.pred[2] | imm.fence.pred[0];
	assign pred_l = imm.fence.pred[3] | imm.fence.pred[1];
	assign succ_s = imm.fence.succ[2] | imm.fence.succ[0];
	assign succ_l = imm.fence.succ[3] | imm.fence.succ[1];

	// fence.i waits for both memory queues to drain
	assign fence_hold = is_fence_i ? (~su_empty | ~lu_empty) :
		((pred_s & succ_s & ~su_empty) | (pred_l & (succ_s | succ_l) & ~lu_empty));

	// a fence goes to the reorder buffer only
	assign fence_go = disp_ok & is_fence & ~fence_hold;

	assign iq_pop = alu_push | bru_push | lu_push | su_push | csr_push | fence_go;
	assign rob_push = iq_pop;

	assign rob_info = {
		pc, rd_tag, has_rd,
		cls == ooo_dispatch_pkg::CLS_BRU,
		cls == ooo_dispatch_pkg::CLS_SU,
		cls == ooo_dispatch_pkg::CLS_CSR,
		is_fence
	};

	assign issue_info = {op, pc, imm, rd_tag, rs1_tag, rs2_tag};

	rename u_rename (
		.clk       (clk),
		.arst_n    (arst_n),
		.rs1       (rs1),
		.rs2       (rs2),
		.rs1_tag   (rs1_tag),
		.rs2_tag   (rs2_tag),
		.rd        (rd),
		.rd_valid  (has_rd),
		.rd_alloc  (iq_pop),
		.rd_tag    (rd_tag),
		.run_out   (run_out),
		.rel_valid (rel_valid),
		.rel_tag   (rel_tag)
	);

endmodule

// ==== hdl/dispatch_fifo.sv ====
`timescale 1ns/100ps

module dispatch_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             push,
	output logic             full,
	input  logic [WIDTH-1:0] wdata,
	input  logic             pop,
	output logic             empty,
	output logic [WIDTH-1:0] rdata
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// head stays visible until popped
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

endmodule

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/100ps

module dispatch_top (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic                                 instr_push,
	output logic                                 instr_full,
	input  logic [ooo_dispatch_pkg::INSTR_W-1:0] instr_word,
	input  logic                                 alu_pop,
	output logic                                 alu_empty,
	output logic [ooo_dispatch_pkg::ISSUE_W-1:0] alu_data,
	input  logic                                 bru_pop,
	output logic                                 bru_empty,
	output logic [ooo_dispatch_pkg::ISSUE_W-1:0] bru_data,
	input  logic                                 lu_pop,
	output logic                                 lu_empty,
	output logic [ooo_dispatch_pkg::ISSUE_W-1:0] lu_data,
	input  logic                                 su_pop,
	output logic                                 su_empty,
	output logic [ooo_dispatch_pkg::ISSUE_W-1:0] su_data,
	input  logic                                 csr_pop,
	output logic                                 csr_empty,
	output logic [ooo_dispatch_pkg::ISSUE_W-1:0] csr_data,
	input  logic                                 rob_pop,
	output logic                                 rob_empty,
	output logic [ooo_dispatch_pkg::ROB_W-1:0]   rob_head
);

	localparam int ROB_W = ooo_dispatch_pkg::ROB_W;
	localparam int PC_W = ooo_dispatch_pkg::PC_W;
	localparam int TAG_W = ooo_dispatch_pkg::TAG_W;
	localparam int ISSUE_W = ooo_dispatch_pkg::ISSUE_W;
	localparam int IQ_DEPTH = ooo_dispatch_pkg::IQ_DEPTH;

	logic                                 iq_empty;
	logic [ooo_dispatch_pkg::INSTR_W-1:0] iq_head;
	logic                                 iq_pop;
	logic                                 rob_full;
	logic                                 rob_push;
	logic [ROB_W-1:0]                     rob_info;
	logic                                 alu_full;
	logic                                 bru_full;
	logic                                 lu_full;
	logic                                 su_full;
	logic                                 csr_full;
	logic                                 alu_push;
	logic                                 bru_push;
	logic                                 lu_push;
	logic                                 su_push;
	logic                                 csr_push;
	logic [ISSUE_W-1:0]                   issue_info;
	logic                                 rel_valid;
	logic [TAG_W-1:0]                     rel_tag;

	// retire releases the rd tag of the popped reorder entry
	assign rel_tag = rob_head[ROB_W-PC_W-1 -: TAG_W];
	assign rel_valid = rob_pop & ~rob_empty & rob_head[ROB_W-PC_W-TAG_W-1];

	dispatch_fifo #(.WIDTH(ooo_dispatch_pkg::INSTR_W), .DEPTH(IQ_DEPTH)) u_iq (
		.clk(clk), .arst_n(arst_n),
		.push(instr_push), .full(instr_full), .wdata(instr_word),
		.pop(iq_pop), .empty(iq_empty), .rdata(iq_head)
	);

	dispatch_fifo #(.WIDTH(ISSUE_W), .DEPTH(IQ_DEPTH)) u_alu_q (
		.clk(clk), .arst_n(arst_n),
		.push(alu_push), .full(alu_full), .wdata(issue_info),
		.pop(alu_pop), .empty(alu_empty), .rdata(alu_data)
	);

	dispatch_fifo #(.WIDTH(ISSUE_W), .DEPTH(IQ_DEPTH)) u_bru_q (
		.clk(clk), .arst_n(arst_n),
		.push(bru_push), .full(bru_full), .wdata(issue_info),
		.pop(bru_pop), .empty(bru_empty), .rdata(bru_data)
	);

	dispatch_fifo #(.WIDTH(ISSUE_W), .DEPTH(IQ_DEPTH)) u_lu_q (
		.clk(clk), .arst_n(arst_n),
		.push(lu_push), .full(lu_full), .wdata(issue_info),
		.pop(lu_pop), .empty(lu_empty), .rdata(lu_data)
	);

	dispatch_fifo #(.WIDTH(ISSUE_W), .DEPTH(IQ_DEPTH)) u_su_q (
		.clk(clk), .arst_n(arst_n),
		.push(su_push), .full(su_full), .wdata(issue_info),
		.pop(su_pop), .empty(su_empty), .rdata(su_data)
	);

	dispatch_fifo #(.WIDTH(ISSUE_W), .DEPTH(IQ_DEPTH)) u_csr_q (
		.clk(clk), .arst_n(arst_n),
		.push(csr_push), .full(csr_full), .wdata(issue_info),
		.pop(csr_pop), .empty(csr_empty), .rdata(csr_data)
	);

	dispatch_fifo #(.WIDTH(ROB_W), .DEPTH(ooo_dispatch_pkg::ROB_DEPTH)) u_rob (
		.clk(clk), .arst_n(arst_n),
		.push(rob_push), .full(rob_full), .wdata(rob_info),
		.pop(rob_pop), .empty(rob_empty), .rdata(rob_head)
	);

	dispatch u_dispatch (
		.clk        (clk),
		.arst_n     (arst_n),
		.iq_empty   (iq_empty),
		.iq_head    (iq_head),
		.iq_pop     (iq_pop),
		.rob_full   (rob_full),
		.rob_push   (rob_push),
		.rob_info   (rob_info),
		.alu_full   (alu_full),
		.bru_full   (bru_full),
		.lu_full    (lu_full),
		.su_full    (su_full),
		.csr_full   (csr_full),
		.alu_push   (alu_push),
		.bru_push   (bru_push),
		.lu_push    (lu_push),
		.su_push    (su_push),
		.csr_push   (csr_push),
		.issue_info (issue_info),
		.su_empty   (su_empty),
		.lu_empty   (lu_empty),
		.rel_valid  (rel_valid),
		.rel_tag    (rel_tag)
	);

endmodule

// ==== hdl/ooo_dispatch_pkg.sv ====
package ooo_dispatch_pkg;

	localparam int ARCH_REGS = 32;
	localparam int REG_W = 5;

	// physical copies per architectural register
	localparam int RB = 4;
	localparam int RB_W = $clog2(RB);

	// renamed tag is {register, copy}
	localparam int TAG_W = REG_W + RB_W;

	localparam int PC_W = 32;
	localparam int IMM_W = 12;
	localparam int OP_W = 4;
	localparam int CLS_W = 3;

	// micro-instruction, msb first: cls, op, pc, imm, rd, rs1, rs2, has_rd
	localparam int INSTR_W = CLS_W + OP_W + PC_W + IMM_W + 3 * REG_W + 1;

	// reorder entry, msb first: pc, rd tag, has_rd, is_branch, is_store, is_csr, is_fence
	localparam int ROB_W = PC_W + TAG_W + 5;

	// issue entry, msb first: op, pc, imm, rd tag, rs1 tag, rs2 tag
	localparam int ISSUE_W = OP_W + PC_W + IMM_W + 3 * TAG_W;

	localparam int IQ_DEPTH = 4;
	localparam int ROB_DEPTH = 8;

	localparam logic [CLS_W-1:0] CLS_ALU = 3'd0;
	localparam logic [CLS_W-1:0] CLS_BRU = 3'd1;
	localparam logic [CLS_W-1:0] CLS_LU = 3'd2;
	localparam logic [CLS_W-1:0] CLS_SU = 3'd3;
	localparam logic [CLS_W-1:0] CLS_CSR = 3'd4;
	localparam logic [CLS_W-1:0] CLS_FENCE = 3'd5;

	// opcodes inside the fence class
	localparam logic [OP_W-1:0] OP_FENCE = 4'd0;
	localparam logic [OP_W-1:0] OP_FENCE_I = 4'd1;

	// set bits: 3 input, 2 output, 1 read, 0 write
	typedef union packed {
		logic [IMM_W-1:0] csr_addr;
		struct packed {
			logic [3:0] unused;
			logic [3:0] pred;
			logic [3:0] succ;
		} fence;
	} imm_u;

endpackage

// ==== hdl/rename.sv ====
`timescale 1ns/100ps

module rename (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic [ooo_dispatch_pkg::REG_W-1:0] rs1,
	input  logic [ooo_dispatch_pkg::REG_W-1:0] rs2,
	output logic [ooo_dispatch_pkg::TAG_W-1:0] rs1_tag,
	output logic [ooo_dispatch_pkg::TAG_W-1:0] rs2_tag,
	input  logic [ooo_dispatch_pkg::REG_W-1:0] rd,
	input  logic                               rd_valid,
	input  logic                               rd_alloc,
	output logic [ooo_dispatch_pkg::TAG_W-1:0] rd_tag,
	output logic                               run_out,
	input  logic                               rel_valid,
	input  logic [ooo_dispatch_pkg::TAG_W-1:0] rel_tag
);

	localparam int REG_W = ooo_dispatch_pkg::REG_W;
	localparam int RB_W = ooo_dispatch_pkg::RB_W;
	localparam int RB = ooo_dispatch_pkg::RB;
	localparam int TAG_W = ooo_dispatch_pkg::TAG_W;

	// active copy and in-use mask per architectural register
	logic [RB_W-1:0] act [ooo_dispatch_pkg::ARCH_REGS];
	logic [RB-1:0]   used [ooo_dispatch_pkg::ARCH_REGS];

	logic [RB_W-1:0]  rd_next;
	logic [REG_W-1:0] rel_reg;
	logic [RB_W-1:0]  rel_prev;

	assign rs1_tag = {rs1, act[rs1]};
	assign rs2_tag = {rs2, act[rs2]};

	// round robin, RB is a power of two so the copy index wraps by itself
	assign rd_next = act[rd] + 1'b1;
	assign rd_tag = {rd, rd_next};
	assign run_out = rd_valid & used[rd][rd_next];

	// a retiring write makes the copy it replaced dead,
	// copies are allocated and retired in order per register
	assign rel_reg = rel_tag[TAG_W-1 -: REG_W];
	assign rel_prev = rel_tag[RB_W-1:0] - 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ooo_dispatch_pkg::ARCH_REGS; i++) begin
				act[i] <= '0;
				used[i] <= RB'(1);
			end
		end else begin
			if (rel_valid) begin
				used[rel_reg][rel_prev] <= 1'b0;
			end
			if (rd_alloc & rd_valid) begin
				act[rd] <= rd_next;
				used[rd][rd_next] <= 1'b1;
			end
		end
	end

endmodule

// ==== ooo_dispatch.f ====
hdl/ooo_dispatch_pkg.sv
hdl/dispatch_fifo.sv
hdl/rename.sv
hdl/dispatch.sv
hdl/dispatch_top.sv
dv/dispatch_properties.sv
dv/dispatch_checker.sv
dv/dispatch_tb.sv
